/* tb.f */
+incdir+sim
hw/video_pkg.sv
hw/video_ports.sv
hw/video_sync.sv
hw/video_fetch.sv
hw/video_linebuf.sv
hw/video_render.sv
hw/video_out.sv
hw/video_top.sv
sim/video_tb.sv

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module video_tb \
	-o video_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "no pass line found in sim.log"
	exit 1
fi
exit 0

/* sim/video_model.svh */
// reference model of the video pipeline, stepped once per clock cycle

// raster counters of the current cycle
int unsigned m_h;
int unsigned m_v;
logic m_frame;
logic m_int;

// written copies and the copies the raster uses
logic [7:0] w_border;
logic [7:0] w_vpage;
logic [1:0] w_mode;
logic [3:0] w_palsel;
logic [8:0] w_vint;
logic [7:0] a_border;
logic [7:0] a_vpage;
logic [1:0] a_mode;
logic [3:0] a_palsel;
logic [8:0] a_vint;

logic [5:0] m_pal [0:255];
bit m_pal_ok [0:255];

// index seen by the palette this cycle, and the expected outputs
logic [7:0] m_idx;
logic [2:0] m_sync_r;
logic [2:0] m_sync_out;
logic [5:0] m_col_out;
bit m_col_ok;

// contents of the simulated DRAM
function automatic logic [15:0] dram_word(input logic [20:0] addr);
	logic [31:0] p;
	p = 32'(addr) * 32'd40503 + 32'd7;
	return p[15:0];
endfunction

function automatic logic [7:0] pixel_index(input int unsigned h, input int unsigned v);
	int unsigned col;
	int unsigned row;
	logic [15:0] w;
	if (h < HPIX_BEG || h >= HPIX_BEG + HPIX_W || v < VPIX_BEG || v >= VPIX_BEG + VPIX_H) begin
		return a_border;
	end
	col = h - HPIX_BEG;
	row = v - VPIX_BEG;
	if (a_mode == 2'd0) begin
		w = dram_word(21'(a_vpage * 256 + row * 8 + col / 2));
		return (col % 2 == 1) ? w[15:8] : w[7:0];
	end
	if (a_mode == 2'd1) begin
		w = dram_word(21'(a_vpage * 256 + row * 8 + col / 4));
		return {a_palsel, 4'(w >> (4 * (col % 4)))};
	end
	return a_border;
endfunction

task automatic model_reset();
	m_h = 0;
	m_v = 0;
	m_frame = 1'b0;
	m_int = 1'b0;
	{w_border, w_vpage, w_mode, w_palsel, w_vint} = '0;
	{a_border, a_vpage, a_mode, a_palsel, a_vint} = '0;
	m_idx = '0;
	m_sync_r = '0;
	m_sync_out = '0;
	m_col_out = '0;
	m_col_ok = 1'b1;
	for (int i = 0; i < 256; i++) begin
		m_pal_ok[i] = 1'b0;
	end
endtask

task automatic model_step();
	int unsigned hn;
	int unsigned vn;
	// colour register reads the palette before this edge's write
	m_col_out = m_pal[m_idx];
	m_col_ok = m_pal_ok[m_idx];
	m_idx = pixel_index(m_h, m_v);
	m_sync_out = m_sync_r;
	m_sync_r = {m_h < H_SYNC, m_v < V_SYNC, (m_h < H_SYNC) ^ (m_v < V_SYNC)};
	hn = (m_h == H_TOTAL - 1) ? 0 : m_h + 1;
	vn = m_v;
	if (m_h == H_TOTAL - 1) begin
		vn = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
	end
	m_int = (hn == 0) && (vn == a_vint);
	if (m_frame) begin
		if (a_vint != w_vint) begin
			vint_moved = 1'b1;
		end
		{a_border, a_vpage, a_mode, a_palsel, a_vint} =
			{w_border, w_vpage, w_mode, w_palsel, w_vint};
	end
	m_frame = (hn == 0) && (vn == 0);
	if (border_wr) w_border = d;
	if (vpage_wr) w_vpage = d;
	if (vconf_wr) w_mode = d[1:0];
	if (palsel_wr) w_palsel = d[3:0];
	if (vint_beg_wr) w_vint = {1'b0, d};
	if (cram_we) begin
		m_pal[zma] = zmd;
		m_pal_ok[zma] = 1'b1;
	end
	m_h = hn;
	m_v = vn;
endtask

/* sim/video_tb.sv */
`timescale 1ns/1ps

module video_tb;

	localparam int H_TOTAL  = 48;
	localparam int H_SYNC   = 4;
	localparam int HPIX_BEG = 16;
	localparam int HPIX_W   = 16;
	localparam int V_TOTAL  = 20;
	localparam int V_SYNC   = 2;
	localparam int VPIX_BEG = 4;
	localparam int VPIX_H   = 8;
	localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
	localparam int N_TESTS = 4;
	// two frames per test, plus room for the register and palette writes
	localparam int TIMEOUT = (N_TESTS * 2 + 2) * FRAME_CYC;

	localparam int REG_BORDER = 0;
	localparam int REG_VPAGE  = 1;
	localparam int REG_VCONF  = 2;
	localparam int REG_PALSEL = 3;
	localparam int REG_VINT   = 4;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] d;
	logic border_wr;
	logic vpage_wr;
	logic vconf_wr;
	logic palsel_wr;
	logic vint_beg_wr;
	logic cram_we;
	logic [7:0] zma;
	logic [5:0] zmd;
	logic [20:0] video_addr;
	logic video_go;
	logic video_strobe = 1'b0;
	logic [15:0] dram_rdata = '0;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;
	logic hsync;
	logic vsync;
	logic csync;
	logic int_start;

	int unsigned stim_seed = 32;
	int unsigned dram_seed = 32;
	int unsigned wait_cnt = 0;
	logic go_s = 1'b0;
	logic [20:0] addr_s = '0;
	int unsigned req_cnt;
	int unsigned ints_in_frame;
	int unsigned frames_seen;
	bit vint_moved;
	int unsigned checks = 0;
	int unsigned errors = 0;
	int unsigned test_checks0;
	int unsigned test_errors0;
	int unsigned cycles = 0;
	string test_name;

	`include "video_model.svh"

	video_top #(
		.H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC), .HPIX_BEG (HPIX_BEG), .HPIX_W (HPIX_W),
		.V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC), .VPIX_BEG (VPIX_BEG), .VPIX_H (VPIX_H)
	) dut0 (
		.clk (clk), .rst (rst), .d (d),
		.border_wr (border_wr), .vpage_wr (vpage_wr), .vconf_wr (vconf_wr),
		.palsel_wr (palsel_wr), .vint_beg_wr (vint_beg_wr),
		.cram_we (cram_we), .zma (zma), .zmd (zmd),
		.video_addr (video_addr), .video_go (video_go),
		.video_strobe (video_strobe), .dram_rdata (dram_rdata),
		.vred (vred), .vgrn (vgrn), .vblu (vblu),
		.hsync (hsync), .vsync (vsync), .csync (csync), .int_start (int_start)
	);

	always #20 clk = ~clk;

	function automatic int unsigned lcg(inout int unsigned state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state >> 8;
	endfunction

	task automatic check_val(input string name, input int unsigned got, input int unsigned exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Error: time %0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_outputs();
		check_val("hsync", hsync, m_sync_out[2]);
		check_val("vsync", vsync, m_sync_out[1]);
		check_val("csync", csync, m_sync_out[0]);
		check_val("int_start", int_start, m_int);
		if (m_col_ok) begin
			check_val("vred", vred, m_col_out[5:4]);
			check_val("vgrn", vgrn, m_col_out[3:2]);
			check_val("vblu", vblu, m_col_out[1:0]);
		end
		// a frame whose vint_beg just moved may legally see two pulses
		if (m_frame) begin
			if (frames_seen > 0 && !vint_moved) begin
				checks++;
				assert (ints_in_frame == 1) else begin
					errors++;
					$display("int_start pulsed %0d times in one frame instead of once",
						ints_in_frame);
				end
			end
			frames_seen++;
			ints_in_frame = 0;
			vint_moved = 1'b0;
		end
		if (int_start) ints_in_frame++;
	endtask

	task automatic check_fetch();
		bit fl;
		logic [20:0] exp_addr;
		fl = (m_v >= VPIX_BEG - 1) && (m_v <= VPIX_BEG + VPIX_H - 2);
		if (video_go && !go_s) begin
			exp_addr = 21'(a_vpage * 256 + (m_v - (VPIX_BEG - 1)) * 8 + req_cnt);
			req_cnt++;
			check_val("video_addr", video_addr, exp_addr);
			checks++;
			assert (fl) else begin
				errors++;
				$display("DRAM request issued on line %0d, which needs no fetch", m_v);
			end
		end
		if (m_h == H_TOTAL - 1) begin
			checks++;
			assert (req_cnt == (fl ? HPIX_W / 2 : 0)) else begin
				errors++;
				$display("line %0d issued %0d DRAM requests", m_v, req_cnt);
			end
			req_cnt = 0;
		end
	endtask

	// model and checks run on the falling edge, where all outputs are settled
	always @(negedge clk) begin
		if (rst) begin
			model_reset();
			req_cnt = 0;
			ints_in_frame = 0;
			frames_seen = 0;
			vint_moved = 1'b0;
		end else begin
			check_outputs();
			check_fetch();
			model_step();
		end
		go_s = video_go;
		addr_s = video_addr;
	end

	// DRAM responder, 1 to 4 cycles from request to strobe
	always @(posedge clk) begin
		if (rst) begin
			video_strobe <= 1'b0;
			wait_cnt <= 0;
		end else if (video_strobe) begin
			video_strobe <= 1'b0;
		end else if (go_s) begin
			if (wait_cnt == 0) begin
				video_strobe <= 1'b1;
				dram_rdata <= dram_word(addr_s);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else begin
			wait_cnt <= lcg(dram_seed) % 4;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic reg_write(input int sel, input logic [7:0] val);
		@(posedge clk);
		d <= val;
		border_wr <= (sel == REG_BORDER);
		vpage_wr <= (sel == REG_VPAGE);
		vconf_wr <= (sel == REG_VCONF);
		palsel_wr <= (sel == REG_PALSEL);
		vint_beg_wr <= (sel == REG_VINT);
		cram_we <= 1'b0;
	endtask

	task automatic pal_write(input logic [7:0] idx, input logic [5:0] val);
		@(posedge clk);
		{border_wr, vpage_wr, vconf_wr, palsel_wr, vint_beg_wr} <= '0;
		cram_we <= 1'b1;
		zma <= idx;
		zmd <= val;
	endtask

	task automatic idle();
		@(posedge clk);
		{border_wr, vpage_wr, vconf_wr, palsel_wr, vint_beg_wr} <= '0;
		cram_we <= 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge clk);
			if (m_frame) seen++;
		end
	endtask

	task automatic test_begin(input string name);
		test_name = name;
		test_checks0 = checks;
		test_errors0 = errors;
	endtask

	task automatic test_end();
		$display("test %s: %0d checks, %0d errors", test_name,
			checks - test_checks0, errors - test_errors0);
	endtask

	initial begin
		int i;
		logic [7:0] border_idx;
		rst = 1'b1;
		d = '0;
		{border_wr, vpage_wr, vconf_wr, palsel_wr, vint_beg_wr} = '0;
		cram_we = 1'b0;
		zma = '0;
		zmd = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		test_begin("bitmap_8bpp");
		for (i = 0; i < 256; i++) begin
			pal_write(8'(i), 6'(lcg(stim_seed)));
		end
		reg_write(REG_VPAGE, 8'(lcg(stim_seed)));
		reg_write(REG_BORDER, 8'(lcg(stim_seed)));
		reg_write(REG_VCONF, 8'd0);
		idle();
		wait_frames(2);
		test_end();

		test_begin("bitmap_4bpp");
		reg_write(REG_VCONF, 8'd1);
		reg_write(REG_PALSEL, 8'(lcg(stim_seed)));
		reg_write(REG_VPAGE, 8'(lcg(stim_seed)));
		idle();
		wait_frames(2);
		test_end();

		test_begin("border_palette");
		// new border colour and a fresh palette entry for it
		border_idx = 8'(lcg(stim_seed));
		reg_write(REG_BORDER, border_idx);
		pal_write(border_idx, 6'(lcg(stim_seed)));
		for (i = 0; i < 8; i++) begin
			pal_write(8'(lcg(stim_seed)), 6'(lcg(stim_seed)));
		end
		reg_write(REG_VCONF, 8'd2);
		idle();
		wait_frames(2);
		test_end();

		test_begin("vint");
		reg_write(REG_VINT, 8'(1 + lcg(stim_seed) % (V_TOTAL - 1)));
		reg_write(REG_VCONF, 8'd0);
		idle();
		wait_frames(2);
		test_end();

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* hw/video_top.sv */
`timescale 1ns/1ps

module video_top #(
	parameter int H_TOTAL  = 48,
	parameter int H_SYNC   = 4,
	parameter int HPIX_BEG = 16,
	parameter int HPIX_W   = 16,
	parameter int V_TOTAL  = 20,
	parameter int V_SYNC   = 2,
	parameter int VPIX_BEG = 4,
	parameter int VPIX_H   = 8
) (
	input  logic        clk,
	input  logic        rst,
	// cpu port writes
	input  logic [7:0]  d,
	input  logic        border_wr,
	input  logic        vpage_wr,
	input  logic        vconf_wr,
	input  logic        palsel_wr,
	input  logic        vint_beg_wr,
	// palette writes
	input  logic        cram_we,
	input  logic [7:0]  zma,
	input  logic [5:0]  zmd,
	// dram
	output logic [20:0] video_addr,
	output logic        video_go,
	input  logic        video_strobe,
	input  logic [15:0] dram_rdata,
	// video out
	output logic [1:0]  vred,
	output logic [1:0]  vgrn,
	output logic [1:0]  vblu,
	output logic        hsync,
	output logic        vsync,
	output logic        csync,
	output logic        int_start
);

	video_pkg::video_cfg_t  cfg;
	video_pkg::raster_pos_t pos;
	video_pkg::lb_wr_t      lb_wr;
	logic        line_start;
	logic        frame_start;
	logic        raw_hsync;
	logic        raw_vsync;
	logic        raw_csync;
	logic [4:0]  lb_raddr;
	logic [15:0] lb_rdata;
	logic [7:0]  index;
	logic [2:0]  syncs_d;

	video_ports video_ports (
		.clk         (clk),
		.rst         (rst),
		.d           (d),
		.border_wr   (border_wr),
		.vpage_wr    (vpage_wr),
		.vconf_wr    (vconf_wr),
		.palsel_wr   (palsel_wr),
		.vint_beg_wr (vint_beg_wr),
		.frame_start (frame_start),
		.cfg         (cfg)
	);

	video_sync #(
		.H_TOTAL  (H_TOTAL),
		.H_SYNC   (H_SYNC),
		.HPIX_BEG (HPIX_BEG),
		.HPIX_W   (HPIX_W),
		.V_TOTAL  (V_TOTAL),
		.V_SYNC   (V_SYNC),
		.VPIX_BEG (VPIX_BEG),
		.VPIX_H   (VPIX_H)
	) video_sync (
		.clk         (clk),
		.rst         (rst),
		.vint_beg    (cfg.vint_beg),
		.pos         (pos),
		.line_start  (line_start),
		.frame_start (frame_start),
		.int_start   (int_start),
		.hsync       (raw_hsync),
		.vsync       (raw_vsync),
		.csync       (raw_csync)
	);

	video_fetch #(
		.HPIX_BEG (HPIX_BEG),
		.VPIX_BEG (VPIX_BEG),
		.VPIX_H   (VPIX_H),
		.HPIX_W   (HPIX_W)
	) video_fetch (
		.clk          (clk),
		.rst          (rst),
		.pos          (pos),
		.line_start   (line_start),
		.vpage        (cfg.vpage),
		.video_strobe (video_strobe),
		.dram_rdata   (dram_rdata),
		.video_go     (video_go),
		.video_addr   (video_addr),
		.lb_wr        (lb_wr)
	);

	// the fetch fills the half for the next line
	video_linebuf video_linebuf (
		.clk     (clk),
		.lb_wr   (lb_wr),
		.wr_half (~pos.vcnt[0]),
		.raddr   (lb_raddr),
		.rdata   (lb_rdata)
	);

	video_render #(
		.HPIX_BEG (HPIX_BEG)
	) video_render (
		.clk       (clk),
		.rst       (rst),
		.pos       (pos),
		.cfg       (cfg),
		.lb_rdata  (lb_rdata),
		.lb_raddr  (lb_raddr),
		.index     (index),
		.syncs_in  ({raw_hsync, raw_vsync, raw_csync}),
		.syncs_out (syncs_d)
	);

	video_out video_out (
		.clk      (clk),
		.rst      (rst),
		.cram_we  (cram_we),
		.zma      (zma),
		.zmd      (zmd),
		.index    (index),
		.syncs_in (syncs_d),
		.vred     (vred),
		.vgrn     (vgrn),
		.vblu     (vblu),
		.hsync    (hsync),
		.vsync    (vsync),
		.csync    (csync)
	);

endmodule

/* hw/video_out.sv */
`timescale 1ns/1ps

module video_out (
	input  logic       clk,
	input  logic       rst,
	input  logic       cram_we,
	input  logic [7:0] zma,
	input  logic [5:0] zmd,
	input  logic [7:0] index,
	input  logic [2:0] syncs_in,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic       hsync,
	output logic       vsync,
	output logic       csync
);

	// palette, red in the top bits
	logic [video_pkg::pal_entry_w-1:0] cram [0:255];
	logic [video_pkg::pal_entry_w-1:0] colour;

	always_ff @(posedge clk) begin
		if (cram_we) begin
			cram[zma] <= zmd;
		end
	end

	// lookup and syncs land on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			colour <= '0;
			hsync  <= 1'b0;
			vsync  <= 1'b0;
			csync  <= 1'b0;
		end else begin
			colour <= cram[index];
			hsync  <= syncs_in[2];
			vsync  <= syncs_in[1];
			csync  <= syncs_in[0];
		end
	end

	assign vred = colour[5:4];
	assign vgrn = colour[3:2];
	assign vblu = colour[1:0];

endmodule

/* hw/video_render.sv */
`timescale 1ns/1ps

module video_render #(
	parameter int HPIX_BEG = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  video_pkg::raster_pos_t pos,
	input  video_pkg::video_cfg_t  cfg,
	input  logic [15:0]            lb_rdata,
	output logic [4:0]             lb_raddr,
	output logic [7:0]             index,
	input  logic [2:0]             syncs_in,
	output logic [2:0]             syncs_out
);

	localparam int WBASE = HPIX_BEG / 2;

	logic [8:0] col;
	logic [1:0] sel;
	logic win;
	video_pkg::render_mode_t mode_r;
	logic [7:0] border_r;
	logic [3:0] palsel_r;

	// pixel column inside the window
	assign col = pos.hcnt - 9'(HPIX_BEG);

	always_comb begin
		if (cfg.mode == video_pkg::mode_4bpp) begin
			lb_raddr = 5'(WBASE) + 5'(col >> 2);
		end else begin
			lb_raddr = 5'(WBASE) + 5'(col >> 1);
		end
	end

	// stage alongside the buffer read
	always_ff @(posedge clk) begin
		if (rst) begin
			sel       <= '0;
			win       <= 1'b0;
			mode_r    <= video_pkg::mode_8bpp;
			border_r  <= '0;
			palsel_r  <= '0;
			syncs_out <= '0;
		end else begin
			sel       <= col[1:0];
			win       <= pos.hpix && pos.vpix;
			mode_r    <= cfg.mode;
			border_r  <= cfg.border;
			palsel_r  <= cfg.palsel;
			syncs_out <= syncs_in;
		end
	end

	always_comb begin
		case (mode_r)
			video_pkg::mode_8bpp: index = sel[0] ? lb_rdata[15:8] : lb_rdata[7:0];
			video_pkg::mode_4bpp: index = {palsel_r, 4'(lb_rdata >> {sel, 2'b00})};
			// border mode and the unused encoding
			default: index = border_r;
		endcase
		if (!win) begin
			index = border_r;
		end
	end

endmodule

/* hw/video_linebuf.sv */
`timescale 1ns/1ps

module video_linebuf (
	input  logic              clk,
	input  video_pkg::lb_wr_t lb_wr,
	input  logic              wr_half,
	input  logic [4:0]        raddr,
	output logic [15:0]       rdata
);

	// two halves of 32 words, half select is the top address bit
	logic [15:0] mem [0:63];

	always_ff @(posedge clk) begin
		if (lb_wr.we) begin
			mem[{wr_half, lb_wr.waddr}] <= lb_wr.wdata;
		end
	end

	// read side always on the other half
	always_ff @(posedge clk) begin
		rdata <= mem[{~wr_half, raddr}];
	end

endmodule

/* hw/video_fetch.sv */
`timescale 1ns/1ps

module video_fetch #(
	parameter int HPIX_BEG = 16,
	parameter int VPIX_BEG = 4,
	parameter int VPIX_H   = 8,
	parameter int HPIX_W   = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  video_pkg::raster_pos_t pos,
	input  logic                   line_start,
	input  logic [7:0]             vpage,
	input  logic                   video_strobe,
	input  logic [15:0]            dram_rdata,
	output logic                   video_go,
	output logic [20:0]            video_addr,
	output video_pkg::lb_wr_t      lb_wr
);

	// two 8bpp pixels per word
	localparam int NWORDS = HPIX_W / 2;
	localparam int WORD_W = $clog2(NWORDS);
	// words sit at their 8bpp column in the buffer
	localparam int WBASE = HPIX_BEG / 2;

	video_pkg::fetch_state_t state;
	logic [WORD_W-1:0] word;
	logic [8:0] row;
	logic fetch_line;

	// line before each window line
	assign fetch_line = (pos.vcnt >= 9'(VPIX_BEG - 1)) && (pos.vcnt <= 9'(VPIX_BEG + VPIX_H - 2));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= video_pkg::idle;
			word  <= '0;
		end else if (line_start) begin
			state <= fetch_line ? video_pkg::wait_data : video_pkg::idle;
			word  <= '0;
		end else begin
			case (state)
				video_pkg::wait_data: begin
					if (video_strobe) begin
						if (word == WORD_W'(NWORDS - 1)) begin
							state <= video_pkg::done;
						end else begin
							state <= video_pkg::request;
							word  <= word + WORD_W'(1);
						end
					end
				end
				// go low for one cycle between words
				video_pkg::request: state <= video_pkg::wait_data;
				default: state <= state;
			endcase
		end
	end

	// display row of the line being fetched
	always_ff @(posedge clk) begin
		if (line_start) begin
			row <= pos.vcnt - 9'(VPIX_BEG - 1);
		end
	end

	assign video_go   = (state == video_pkg::wait_data);
	assign video_addr = (21'(vpage) << 8) + (21'(row) << 3) + 21'(word);

	assign lb_wr.we    = video_go && video_strobe;
	assign lb_wr.waddr = 5'(WBASE) + 5'(word);
	assign lb_wr.wdata = dram_rdata;

	// request held with a steady address until the strobe
	a_go_hold: assert property (
		@(posedge clk) disable iff (rst)
		video_go && !video_strobe |=> video_go && $stable(video_addr)
	);

	// the line fetch has to end before the buffer halves swap
	a_fetch_in_time: assert property (
		@(posedge clk) disable iff (rst)
		line_start |-> !(state inside {video_pkg::request, video_pkg::wait_data})
	);

endmodule

/* hw/video_sync.sv */
`timescale 1ns/1ps

module video_sync #(
	parameter int H_TOTAL  = 48,
	parameter int H_SYNC   = 4,
	parameter int HPIX_BEG = 16,
	parameter int HPIX_W   = 16,
	parameter int V_TOTAL  = 20,
	parameter int V_SYNC   = 2,
	parameter int VPIX_BEG = 4,
	parameter int VPIX_H   = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [8:0]             vint_beg,
	output video_pkg::raster_pos_t pos,
	output logic                   line_start,
	output logic                   frame_start,
	output logic                   int_start,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   csync
);

	localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
	localparam int GAP_W = $clog2(FRAME_LEN + 1);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic [8:0] h_next;
	logic [8:0] v_next;
	logic [GAP_W-1:0] fs_gap;

	always_comb begin
		h_next = (hcnt == 9'(H_TOTAL - 1)) ? 9'd0 : hcnt + 9'd1;
		v_next = vcnt;
		if (hcnt == 9'(H_TOTAL - 1)) begin
			v_next = (vcnt == 9'(V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;
		end
	end

	// pulses are registered from the next position so they line up with hcnt 0
	always_ff @(posedge clk) begin
		if (rst) begin
			hcnt        <= '0;
			vcnt        <= '0;
			line_start  <= 1'b0;
			frame_start <= 1'b0;
			int_start   <= 1'b0;
		end else begin
			hcnt        <= h_next;
			vcnt        <= v_next;
			line_start  <= (h_next == 9'd0);
			frame_start <= (h_next == 9'd0) && (v_next == 9'd0);
			int_start   <= (h_next == 9'd0) && (v_next == vint_beg);
		end
	end

	assign pos.hcnt = hcnt;
	assign pos.vcnt = vcnt;
	assign pos.hpix = (hcnt >= 9'(HPIX_BEG)) && (hcnt < 9'(HPIX_BEG + HPIX_W));
	assign pos.vpix = (vcnt >= 9'(VPIX_BEG)) && (vcnt < 9'(VPIX_BEG + VPIX_H));

	assign hsync = (hcnt < 9'(H_SYNC));
	assign vsync = (vcnt < 9'(V_SYNC));
	assign csync = hsync ^ vsync;

	// cycles since last frame start, saturating
	always_ff @(posedge clk) begin
		if (rst) begin
			fs_gap <= '0;
		end else if (frame_start) begin
			fs_gap <= GAP_W'(1);
		end else if (fs_gap != GAP_W'(FRAME_LEN)) begin
			fs_gap <= fs_gap + GAP_W'(1);
		end
	end

	// one frame start every V_TOTAL lines, never more, never fewer
	a_frame_period: assert property (
		@(posedge clk) disable iff (rst)
		frame_start == (fs_gap == GAP_W'(FRAME_LEN))
	);

endmodule

/* hw/video_ports.sv */
`timescale 1ns/1ps

module video_ports (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            d,
	input  logic                  border_wr,
	input  logic                  vpage_wr,
	input  logic                  vconf_wr,
	input  logic                  palsel_wr,
	input  logic                  vint_beg_wr,
	input  logic                  frame_start,
	output video_pkg::video_cfg_t cfg
);

	// copy as written by the cpu, not yet visible to the raster
	video_pkg::video_cfg_t wr_cfg;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_cfg <= '0;
			cfg    <= '0;
		end else begin
			if (border_wr) begin
				wr_cfg.border <= d;
			end
			if (vpage_wr) begin
				wr_cfg.vpage <= d;
			end
			if (vconf_wr) begin
				wr_cfg.mode <= video_pkg::render_mode_t'(d[1:0]);
			end
			if (palsel_wr) begin
				wr_cfg.palsel <= d[3:0];
			end
			// only 8 bits are reachable, top bit stays clear
			if (vint_beg_wr) begin
				wr_cfg.vint_beg <= {1'b0, d};
			end
			// whole set goes live at once, next frame
			if (frame_start) begin
				cfg <= wr_cfg;
			end
		end
	end

endmodule

/* hw/video_pkg.sv */
package video_pkg;

	// width of one palette entry, 2 bits each for red, green and blue
	localparam int pal_entry_w = 6;

	// pixel format of the bitmap window
	typedef enum logic [1:0] {
		mode_8bpp   = 2'd0,
		mode_4bpp   = 2'd1,
		mode_border = 2'd2
	} render_mode_t;

	// line fetcher states
	typedef enum logic [1:0] {
		idle      = 2'd0,
		request   = 2'd1,
		wait_data = 2'd2,
		done      = 2'd3
	} fetch_state_t;

	// cpu visible video configuration
	typedef struct packed {
		logic [10:0]  rsvd;
		logic [8:0]   vint_beg;
		logic [3:0]   palsel;
		render_mode_t mode;
		logic [7:0]   vpage;
		logic [7:0]   border;
	} video_cfg_t;

	// current raster position and window flags
	typedef struct packed {
		logic       vpix;
		logic       hpix;
		logic [8:0] vcnt;
		logic [8:0] hcnt;
	} raster_pos_t;

	// one line buffer write
	typedef struct packed {
		logic        we;
		logic [4:0]  waddr;
		logic [15:0] wdata;
	} lb_wr_t;

endpackage
